/* verilog/lsu_macros.svh */
// ----------------------------
// lsu sizing macros
// ----------------------------
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

`default_nettype none

// data and address width
`define LSU_XLEN 64
// register file index width
`define LSU_REG_IDX_W 5
// request queue entries, also initial request credits
`define LSU_REQ_DEPTH 4
// initial writeback credits
`define LSU_WB_CREDITS 2
// doublewords in data memory
`define LSU_MEM_WORDS 256

`default_nettype wire

`endif

/* verilog/lsu_pkg.sv */
// ----------------------------
// lsu shared types
// ----------------------------
`include "lsu_macros.svh"

`default_nettype none

package lsu_pkg;

  // doubleword index width into data memory
  localparam int LSU_MEM_IDX_W = $clog2(`LSU_MEM_WORDS);

  // access size
  typedef enum logic [1:0] {
    LS_BYTE   = 2'd0,
    LS_HALF   = 2'd1,
    LS_WORD   = 2'd2,
    LS_DOUBLE = 2'd3
  } ls_size_e;

  // load/store control, 5 bits
  typedef struct packed {
    logic     load;
    logic     store;
    logic     usign;
    ls_size_e size;
  } ls_op_t;

  // one operation from execute
  typedef struct packed {
    ls_op_t                    op;
    logic                      rd_wr_en;
    logic [`LSU_REG_IDX_W-1:0] rd_idx;
    // effective address for loads and stores
    logic [`LSU_XLEN-1:0]      alu_res;
    logic [`LSU_XLEN-1:0]      wdata;
  } lsu_req_t;

endpackage

`default_nettype wire

/* verilog/lsu_op_if.sv */
// ----------------------------
// issued operation bus
// ----------------------------
`include "lsu_macros.svh"

`timescale 1ns/1ps
`default_nettype none

interface lsu_op_if import lsu_pkg::*; ();

  // high for exactly the issue cycle
  logic                      valid;
  ls_op_t                    op;
  logic                      rd_wr_en;
  logic [`LSU_REG_IDX_W-1:0] rd_idx;
  logic [`LSU_XLEN-1:0]      alu_res;
  logic [`LSU_XLEN-1:0]      wdata;

  // no stall, the queue only issues with capacity downstream
  modport issue (
    output valid, op, rd_wr_en, rd_idx, alu_res, wdata
  );

  modport sink (
    input valid, op, rd_wr_en, rd_idx, alu_res, wdata
  );

endinterface

`default_nettype wire

/* verilog/lsu_req_queue.sv */
// ----------------------------
// request queue
// ----------------------------
`include "lsu_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module lsu_req_queue import lsu_pkg::*; (
  input  wire      clk,
  input  wire      reset_i,
  input  wire      req_valid_i,
  input  lsu_req_t req_i,
  output logic     req_credit_o,
  input  wire      wb_credit_i,
  lsu_op_if.issue  issue
);

  localparam int PTR_W    = (`LSU_REQ_DEPTH > 1) ? $clog2(`LSU_REQ_DEPTH) : 1;
  localparam int CNT_W    = $clog2(`LSU_REQ_DEPTH + 1);
  localparam int WB_CNT_W = $clog2(`LSU_WB_CREDITS + 1);

  lsu_req_t             entries_q [`LSU_REQ_DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [CNT_W-1:0]     count_q;
  logic [WB_CNT_W-1:0]  wb_cnt_q;
  logic                 do_issue;
  lsu_req_t             head;

  // pop only with a head entry and a writeback slot reserved
  assign do_issue     = (count_q != '0) && (wb_cnt_q != '0);
  assign req_credit_o = do_issue;
  assign head         = entries_q[rd_ptr_q];

  assign issue.valid    = do_issue;
  assign issue.op       = head.op;
  assign issue.rd_wr_en = head.rd_wr_en;
  assign issue.rd_idx   = head.rd_idx;
  assign issue.alu_res  = head.alu_res;
  assign issue.wdata    = head.wdata;

  // entry storage
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      entries_q[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (req_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`LSU_REQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_issue) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`LSU_REQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({req_valid_i, do_issue})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // writeback credits, spent at issue and returned by writeback
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_cnt_q <= WB_CNT_W'(`LSU_WB_CREDITS);
    end else begin
      case ({do_issue, wb_credit_i})
        2'b10:   wb_cnt_q <= wb_cnt_q - WB_CNT_W'(1);
        2'b01:   wb_cnt_q <= wb_cnt_q + WB_CNT_W'(1);
        default: wb_cnt_q <= wb_cnt_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/lsu_store_unit.sv */
// ----------------------------
// store unit
// ----------------------------
`include "lsu_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module lsu_store_unit import lsu_pkg::*; (
  input  wire                      clk,
  input  wire                      reset_i,
  lsu_op_if.sink                   op,
  output logic                     mem_wen_o,
  output logic [LSU_MEM_IDX_W-1:0] mem_widx_o,
  output logic [7:0]               mem_wmask_o,
  output logic [`LSU_XLEN-1:0]     mem_wdata_o
);

  logic       wen_ok_q;
  logic [7:0] size_mask;
  logic [2:0] offset;

  // held low through reset so stale state cannot write
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wen_ok_q <= 1'b0;
    end else begin
      wen_ok_q <= 1'b1;
    end
  end

  assign offset     = op.alu_res[2:0];
  assign mem_wen_o  = op.valid && op.op.store && wen_ok_q;
  assign mem_widx_o = op.alu_res[3 +: LSU_MEM_IDX_W];

  // lane mask and replicated data per size
  always_comb begin
    case (op.op.size)
      LS_BYTE: begin
        size_mask   = 8'h01;
        mem_wdata_o = {8{op.wdata[7:0]}};
      end
      LS_HALF: begin
        size_mask   = 8'h03;
        mem_wdata_o = {4{op.wdata[15:0]}};
      end
      LS_WORD: begin
        size_mask   = 8'h0f;
        mem_wdata_o = {2{op.wdata[31:0]}};
      end
      default: begin
        size_mask   = 8'hff;
        mem_wdata_o = op.wdata;
      end
    endcase
  end

  // aligned, so the shift never carries past bit 7
  assign mem_wmask_o = size_mask << offset;

endmodule

`default_nettype wire

/* verilog/lsu_load_unit.sv */
// ----------------------------
// load unit
// ----------------------------
`include "lsu_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module lsu_load_unit import lsu_pkg::*; (
  input  wire                      clk,
  input  wire                      reset_i,
  lsu_op_if.sink                   op,
  output logic                     mem_ren_o,
  output logic [LSU_MEM_IDX_W-1:0] mem_ridx_o,
  input  wire  [`LSU_XLEN-1:0]     mem_rdata_i,
  output logic                     ld_valid_o,
  output logic [`LSU_XLEN-1:0]     ld_data_o
);

  logic                 ld_pend_q;
  ls_size_e             size_q;
  logic                 usign_q;
  logic [2:0]           offset_q;
  logic [`LSU_XLEN-1:0] lane;

  assign mem_ren_o  = op.valid && op.op.load;
  assign mem_ridx_o = op.alu_res[3 +: LSU_MEM_IDX_W];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ld_pend_q <= 1'b0;
    end else begin
      ld_pend_q <= mem_ren_o;
    end
  end

  // access shape, needed when the read data returns
  always_ff @(posedge clk) begin
    if (mem_ren_o) begin
      size_q   <= op.op.size;
      usign_q  <= op.op.usign;
      offset_q <= op.alu_res[2:0];
    end
  end

  assign ld_valid_o = ld_pend_q;
  // selected lane moved down to bit 0
  assign lane = mem_rdata_i >> {offset_q, 3'b000};

  always_comb begin
    case (size_q)
      LS_BYTE: ld_data_o = usign_q ? {{(`LSU_XLEN-8){1'b0}}, lane[7:0]}
                                   : {{(`LSU_XLEN-8){lane[7]}}, lane[7:0]};
      LS_HALF: ld_data_o = usign_q ? {{(`LSU_XLEN-16){1'b0}}, lane[15:0]}
                                   : {{(`LSU_XLEN-16){lane[15]}}, lane[15:0]};
      LS_WORD: ld_data_o = usign_q ? {{(`LSU_XLEN-32){1'b0}}, lane[31:0]}
                                   : {{(`LSU_XLEN-32){lane[31]}}, lane[31:0]};
      // ld, signedness does not matter
      default: ld_data_o = lane;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/lsu_data_mem.sv */
// ----------------------------
// data memory
// ----------------------------
`include "lsu_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module lsu_data_mem import lsu_pkg::*; (
  input  wire                      clk,
  input  wire                      wen_i,
  input  wire  [LSU_MEM_IDX_W-1:0] widx_i,
  input  wire  [7:0]               wmask_i,
  input  wire  [`LSU_XLEN-1:0]     wdata_i,
  input  wire                      ren_i,
  input  wire  [LSU_MEM_IDX_W-1:0] ridx_i,
  output logic [`LSU_XLEN-1:0]     rdata_o
);

  logic [`LSU_XLEN-1:0] mem_q [`LSU_MEM_WORDS];

  // byte-enabled write
  always_ff @(posedge clk) begin
    if (wen_i) begin
      for (int b = 0; b < 8; b++) begin
        if (wmask_i[b]) begin
          mem_q[widx_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // registered read, one cycle
  always_ff @(posedge clk) begin
    if (ren_i) begin
      rdata_o <= mem_q[ridx_i];
    end
  end

endmodule

`default_nettype wire

/* verilog/lsu_wb_merge.sv */
// ----------------------------
// writeback merge
// ----------------------------
`include "lsu_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module lsu_wb_merge (
  input  wire                       clk,
  input  wire                       reset_i,
  lsu_op_if.sink                    op,
  input  wire                       ld_valid_i,
  input  wire  [`LSU_XLEN-1:0]      ld_data_i,
  output logic                      wb_valid_o,
  output logic                      wb_rd_wr_en_o,
  output logic [`LSU_REG_IDX_W-1:0] wb_rd_idx_o,
  output logic [`LSU_XLEN-1:0]      wb_rd_data_o
);

  logic                      s1_valid_q;
  logic                      s1_load_q;
  logic                      s1_rd_wr_en_q;
  logic [`LSU_REG_IDX_W-1:0] s1_rd_idx_q;
  logic [`LSU_XLEN-1:0]      s1_alu_res_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      s1_valid_q <= 1'b0;
      wb_valid_o <= 1'b0;
    end else begin
      s1_valid_q <= op.valid;
      wb_valid_o <= s1_valid_q;
    end
  end

  // stage 1 lines up with the load unit's data
  always_ff @(posedge clk) begin
    s1_load_q     <= op.op.load;
    s1_rd_wr_en_q <= op.rd_wr_en;
    s1_rd_idx_q   <= op.rd_idx;
    s1_alu_res_q  <= op.alu_res;
  end

  // stage 2, result select
  always_ff @(posedge clk) begin
    wb_rd_wr_en_o <= s1_rd_wr_en_q;
    wb_rd_idx_o   <= s1_rd_idx_q;
    wb_rd_data_o  <= (s1_load_q && ld_valid_i) ? ld_data_i : s1_alu_res_q;
  end

endmodule

`default_nettype wire

/* verilog/lsu_top.sv */
// ----------------------------
// memory access stage
// ----------------------------
`include "lsu_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
  input  wire                       clk,
  input  wire                       reset_i,
  input  wire                       req_valid_i,
  input  ls_op_t                    req_op_i,
  input  wire                       req_rd_wr_en_i,
  input  wire  [`LSU_REG_IDX_W-1:0] req_rd_idx_i,
  input  wire  [`LSU_XLEN-1:0]      req_alu_res_i,
  input  wire  [`LSU_XLEN-1:0]      req_wdata_i,
  output logic                      req_credit_o,
  output logic                      wb_valid_o,
  output logic                      wb_rd_wr_en_o,
  output logic [`LSU_REG_IDX_W-1:0] wb_rd_idx_o,
  output logic [`LSU_XLEN-1:0]      wb_rd_data_o,
  input  wire                       wb_credit_i
);

  lsu_req_t                 req;
  logic                     mem_wen;
  logic [LSU_MEM_IDX_W-1:0] mem_widx;
  logic [7:0]               mem_wmask;
  logic [`LSU_XLEN-1:0]     mem_wdata;
  logic                     mem_ren;
  logic [LSU_MEM_IDX_W-1:0] mem_ridx;
  logic [`LSU_XLEN-1:0]     mem_rdata;
  logic                     ld_valid;
  logic [`LSU_XLEN-1:0]     ld_data;

  lsu_op_if op_if ();

  assign req = '{op: req_op_i, rd_wr_en: req_rd_wr_en_i, rd_idx: req_rd_idx_i,
                 alu_res: req_alu_res_i, wdata: req_wdata_i};

  lsu_req_queue i_lsu_req_queue (
    .clk, .reset_i, .req_valid_i, .req_i(req), .req_credit_o, .wb_credit_i,
    .issue(op_if.issue)
  );

  // store and load units see the same issued operation
  lsu_store_unit i_lsu_store_unit (
    .clk, .reset_i, .op(op_if.sink), .mem_wen_o(mem_wen), .mem_widx_o(mem_widx),
    .mem_wmask_o(mem_wmask), .mem_wdata_o(mem_wdata)
  );

  lsu_load_unit i_lsu_load_unit (
    .clk, .reset_i, .op(op_if.sink), .mem_ren_o(mem_ren), .mem_ridx_o(mem_ridx),
    .mem_rdata_i(mem_rdata), .ld_valid_o(ld_valid), .ld_data_o(ld_data)
  );

  lsu_data_mem i_lsu_data_mem (
    .clk, .wen_i(mem_wen), .widx_i(mem_widx), .wmask_i(mem_wmask), .wdata_i(mem_wdata),
    .ren_i(mem_ren), .ridx_i(mem_ridx), .rdata_o(mem_rdata)
  );

  lsu_wb_merge i_lsu_wb_merge (
    .clk, .reset_i, .op(op_if.sink), .ld_valid_i(ld_valid), .ld_data_i(ld_data),
    .wb_valid_o, .wb_rd_wr_en_o, .wb_rd_idx_o, .wb_rd_data_o
  );

endmodule

`default_nettype wire

/* testbench/lsu_assertions.sv */
// ----------------------------
// lsu protocol checks
// ----------------------------
`include "lsu_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module lsu_assertions import lsu_pkg::*; (
  input wire                  clk,
  input wire                  reset_i,
  input wire                  req_valid_i,
  input ls_op_t               req_op_i,
  input wire [`LSU_XLEN-1:0]  req_alu_res_i,
  input wire                  req_credit_o,
  input wire                  wb_valid_o,
  input wire                  wb_credit_i
);

  int         credits_q;
  int         outst_q;
  logic [3:0] align_mask;

  // sender credits and issued results not yet credited back
  always_ff @(posedge clk) begin
    if (reset_i) begin
      credits_q <= `LSU_REQ_DEPTH;
      outst_q   <= 0;
    end else begin
      credits_q <= credits_q - int'(req_valid_i) + int'(req_credit_o);
      outst_q   <= outst_q + int'(req_credit_o) - int'(wb_credit_i);
    end
  end

  assign align_mask = (4'd1 << req_op_i.size) - 4'd1;

  assert property (@(posedge clk) disable iff (reset_i) req_valid_i |-> credits_q > 0)
    else $error("request sent without a request credit");

  assert property (@(posedge clk) disable iff (reset_i)
    (req_valid_i && (req_op_i.load || req_op_i.store))
      |-> ((req_alu_res_i[2:0] & align_mask[2:0]) == 3'd0))
    else $error("misaligned load or store address");

  assert property (@(posedge clk) reset_i |=> !wb_valid_o)
    else $error("wb_valid_o high after reset");

  assert property (@(posedge clk) disable iff (reset_i) outst_q <= `LSU_WB_CREDITS)
    else $error("more writeback results in flight than credits");

endmodule

`default_nettype wire

/* testbench/lsu_tb.sv */
// ----------------------------
// lsu testbench
// ----------------------------
`include "lsu_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

  localparam int MAX_OPS = 64;
  localparam int TIMEOUT = 2000;

  logic                      clk;
  logic                      reset_i;
  logic                      req_valid_i;
  ls_op_t                    req_op_i;
  logic                      req_rd_wr_en_i;
  logic [`LSU_REG_IDX_W-1:0] req_rd_idx_i;
  logic [`LSU_XLEN-1:0]      req_alu_res_i;
  logic [`LSU_XLEN-1:0]      req_wdata_i;
  logic                      req_credit_o;
  logic                      wb_valid_o;
  logic                      wb_rd_wr_en_o;
  logic [`LSU_REG_IDX_W-1:0] wb_rd_idx_o;
  logic [`LSU_XLEN-1:0]      wb_rd_data_o;
  logic                      wb_credit_i;

  // golden columns
  logic [1:0]                kind_a [MAX_OPS];
  logic [1:0]                size_a [MAX_OPS];
  logic                      usign_a [MAX_OPS];
  logic                      we_a [MAX_OPS];
  logic [`LSU_REG_IDX_W-1:0] rd_a [MAX_OPS];
  logic [`LSU_XLEN-1:0]      addr_a [MAX_OPS];
  logic [`LSU_XLEN-1:0]      data_a [MAX_OPS];
  logic [`LSU_XLEN-1:0]      exp_a [MAX_OPS];
  string                     name_a [MAX_OPS];

  int     n_ops;
  int     n_sent;
  int     n_recv;
  int     n_returned;
  int     credits_back;
  int     n_err;
  integer seed;
  logic   aborted;

  lsu_top i_lsu_top (
    .clk, .reset_i, .req_valid_i, .req_op_i, .req_rd_wr_en_i, .req_rd_idx_i,
    .req_alu_res_i, .req_wdata_i, .req_credit_o, .wb_valid_o, .wb_rd_wr_en_o,
    .wb_rd_idx_o, .wb_rd_data_o, .wb_credit_i
  );

  bind lsu_top lsu_assertions i_lsu_assertions (
    .clk(clk), .reset_i(reset_i), .req_valid_i(req_valid_i), .req_op_i(req_op_i),
    .req_alu_res_i(req_alu_res_i), .req_credit_o(req_credit_o),
    .wb_valid_o(wb_valid_o), .wb_credit_i(wb_credit_i)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic finish_run();
    $display("errors: %0d, results: %0d of %0d", n_err, n_recv, n_ops);
    if (n_err == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  task automatic load_golden();
    int                        fd;
    int                        cnt;
    string                     line;
    string                     nm;
    logic [1:0]                k;
    logic [1:0]                s;
    logic                      u;
    logic                      w;
    logic [`LSU_REG_IDX_W-1:0] r;
    logic [`LSU_XLEN-1:0]      a;
    logic [`LSU_XLEN-1:0]      d;
    logic [`LSU_XLEN-1:0]      e;
    fd = $fopen("testbench/lsu_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/lsu_golden.txt");
      n_err++;
      aborted = 1'b1;
    end else begin
      while (!$feof(fd) && n_ops < MAX_OPS) begin
        line = "";
        void'($fgets(line, fd));
        // skip comment and blank lines
        if (line.len() > 1 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %s", k, s, u, w, r, a, d, e, nm);
          if (cnt == 9) begin
            kind_a[n_ops]  = k;
            size_a[n_ops]  = s;
            usign_a[n_ops] = u;
            we_a[n_ops]    = w;
            rd_a[n_ops]    = r;
            addr_a[n_ops]  = a;
            data_a[n_ops]  = d;
            exp_a[n_ops]   = e;
            name_a[n_ops]  = nm;
            n_ops++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // sends while the sender still holds request credits
  task automatic send_all();
    int waited;
    waited = 0;
    while (n_sent < n_ops && !aborted) begin
      @(posedge clk);
      if ((`LSU_REQ_DEPTH - n_sent + credits_back) > 0) begin
        req_valid_i       <= 1'b1;
        req_op_i.load     <= (kind_a[n_sent] == 2'd1);
        req_op_i.store    <= (kind_a[n_sent] == 2'd2);
        req_op_i.usign    <= usign_a[n_sent];
        req_op_i.size     <= ls_size_e'(size_a[n_sent]);
        req_rd_wr_en_i    <= we_a[n_sent];
        req_rd_idx_i      <= rd_a[n_sent];
        req_alu_res_i     <= addr_a[n_sent];
        req_wdata_i       <= data_a[n_sent];
        n_sent++;
        waited = 0;
      end else begin
        req_valid_i <= 1'b0;
        waited++;
        if (waited > TIMEOUT) begin
          $display("no request credit came back while requests were waiting");
          n_err++;
          aborted = 1'b1;
        end
      end
    end
    @(posedge clk);
    req_valid_i <= 1'b0;
  endtask

  // returns one writeback credit per result after random gaps
  task automatic return_credits();
    int idle;
    int gap;
    while (n_returned < n_ops && !aborted) begin
      idle = 0;
      while (n_recv == n_returned && idle <= TIMEOUT && !aborted) begin
        @(posedge clk);
        wb_credit_i <= 1'b0;
        idle++;
      end
      if (idle > TIMEOUT) begin
        $display("no writeback result arrived for an outstanding request");
        n_err++;
        aborted = 1'b1;
      end else if (!aborted) begin
        gap = $random(seed) & 15;
        // now and then a long stall
        if (($random(seed) & 7) == 0) begin
          gap = gap + 40;
        end
        repeat (gap) begin
          @(posedge clk);
          wb_credit_i <= 1'b0;
        end
        @(posedge clk);
        wb_credit_i <= 1'b1;
        n_returned++;
      end
    end
    @(posedge clk);
    wb_credit_i <= 1'b0;
  endtask

  task automatic check_result(input int idx);
    if (wb_rd_data_o !== exp_a[idx]) begin
      $display("[ERROR] %s data: expected %h, actual %h", name_a[idx], exp_a[idx], wb_rd_data_o);
      n_err++;
    end
    if (wb_rd_idx_o !== rd_a[idx]) begin
      $display("[ERROR] %s rd: expected %h, actual %h", name_a[idx], rd_a[idx], wb_rd_idx_o);
      n_err++;
    end
    if (wb_rd_wr_en_o !== we_a[idx]) begin
      $display("[ERROR] %s wr_en: expected %b, actual %b", name_a[idx], we_a[idx],
               wb_rd_wr_en_o);
      n_err++;
    end
  endtask

  // mid-cycle monitor for credits and results
  always @(negedge clk) begin
    if (!reset_i && req_credit_o) begin
      credits_back++;
      if (credits_back > n_sent) begin
        $display("request credit returned for a request that was never sent");
        n_err++;
      end
    end
    if (!reset_i && wb_valid_o) begin
      if (n_sent == 0) begin
        $display("wb_valid_o pulsed before any request was sent");
        n_err++;
      end else if (n_recv >= n_ops) begin
        $display("extra writeback result after all expected results");
        n_err++;
      end else begin
        check_result(n_recv);
      end
      n_recv++;
    end
  end

  initial begin
    int waited;
    seed           = 32'hde24_1717;
    n_ops          = 0;
    n_sent         = 0;
    n_recv         = 0;
    n_returned     = 0;
    credits_back   = 0;
    n_err          = 0;
    aborted        = 1'b0;
    reset_i        <= 1'b1;
    req_valid_i    <= 1'b0;
    req_op_i       <= '0;
    req_rd_wr_en_i <= 1'b0;
    req_rd_idx_i   <= '0;
    req_alu_res_i  <= '0;
    req_wdata_i    <= '0;
    wb_credit_i    <= 1'b0;
    load_golden();
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;
    // idle stretch where no result may appear
    repeat (6) @(posedge clk);
    fork
      send_all();
      return_credits();
    join
    // room for a duplicate result to show up
    repeat (10) @(posedge clk);
    waited = 0;
    while (credits_back < n_ops && waited <= TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (credits_back != n_ops) begin
      $display("[ERROR] request_credits: expected %0d, actual %0d", n_ops, credits_back);
      n_err++;
    end
    if (n_recv != n_ops) begin
      $display("[ERROR] result_count: expected %0d, actual %0d", n_ops, n_recv);
      n_err++;
    end
    finish_run();
  end

endmodule

`default_nettype wire

/* testbench/lsu_golden.txt */
# kind (0 alu, 1 load, 2 store)  size (0 b, 1 h, 2 w, 3 d)  unsigned  wr_en  rd
# address or alu result, store data, expected writeback data, test name
2 3 0 0 00 0000000000000100 f0e1d2c3b4a59687 0000000000000100 sd_base
1 0 0 1 01 0000000000000100 0000000000000000 ffffffffffffff87 lb_off0
1 0 1 1 02 0000000000000105 0000000000000000 00000000000000d2 lbu_off5
1 0 0 1 03 0000000000000107 0000000000000000 fffffffffffffff0 lb_off7
1 0 1 1 04 0000000000000103 0000000000000000 00000000000000b4 lbu_off3
1 1 0 1 05 0000000000000102 0000000000000000 ffffffffffffb4a5 lh_off2
1 1 1 1 06 0000000000000106 0000000000000000 000000000000f0e1 lhu_off6
1 1 0 1 07 0000000000000100 0000000000000000 ffffffffffff9687 lh_off0
1 2 0 1 08 0000000000000104 0000000000000000 fffffffff0e1d2c3 lw_off4
1 2 1 1 09 0000000000000100 0000000000000000 00000000b4a59687 lwu_off0
1 2 0 1 0a 0000000000000100 0000000000000000 ffffffffb4a59687 lw_off0
1 3 0 1 0b 0000000000000100 0000000000000000 f0e1d2c3b4a59687 ld_base
2 0 0 0 00 0000000000000101 ffffffffffffff5a 0000000000000101 sb_off1
2 1 0 0 00 0000000000000104 deadbeefcafe1234 0000000000000104 sh_off4
1 3 0 1 0c 0000000000000100 0000000000000000 f0e11234b4a55a87 ld_after_sb_sh
2 3 0 0 00 0000000000000108 0123456789abcdef 0000000000000108 sd_second
2 2 0 0 00 000000000000010c ffffffff7766aa55 000000000000010c sw_off4
1 3 0 1 0d 0000000000000108 0000000000000000 7766aa5589abcdef ld_after_sw
0 0 0 1 0e 00000000deadbeef 0000000000000000 00000000deadbeef alu_result
0 0 0 0 0f 0000000000000123 0000000000000000 0000000000000123 alu_no_write
1 1 1 1 10 000000000000010e 0000000000000000 0000000000007766 lhu_off6_second

/* src.f */
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_op_if.sv
verilog/lsu_req_queue.sv
verilog/lsu_store_unit.sv
verilog/lsu_load_unit.sv
verilog/lsu_data_mem.sv
verilog/lsu_wb_merge.sv
verilog/lsu_top.sv
testbench/lsu_assertions.sv
testbench/lsu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= ERRORS FOUND
PASS_MSG  ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build lsu_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
